//--- fifo_bank_pkg.sv
`default_nettype none

package fifo_bank_pkg;

  // ****************************************
  // Bank geometry
  // ****************************************

  localparam int LANES  = 4;
  localparam int LANE_W = 2;   // Must cover LANES
  localparam int DATA_W = 8;

  localparam int DEPTH  = 16;  // Power of two, Gray pointers rely on it
  localparam int ADDR_W = $clog2(DEPTH);

  // ****************************************
  // Flag thresholds
  // ****************************************

  // Almost-full is judged on the write side count
  localparam int AFULL_LEVEL  = 12;
  localparam int AEMPTY_LEVEL = 2;   // Read side count, inclusive

  // ****************************************
  // Types
  // ****************************************

  typedef logic [LANE_W-1:0] lane_t;

  // Pointer with the extra wrap bit above the RAM address
  typedef logic [ADDR_W:0] ptr_t;

  typedef struct packed {
    lane_t             lane;
    logic [DATA_W-1:0] data;
  } bank_word_t;

endpackage

`default_nettype wire

//--- dualport_ram_async.sv
`timescale 1ns/1ps
`default_nettype none

module dualport_ram_async (
  input  wire                               wr_clk,
  input  wire                               wr_en,
  input  wire  [fifo_bank_pkg::ADDR_W-1:0] wr_addr,
  input  wire  [fifo_bank_pkg::DATA_W-1:0] wr_data,
  input  wire                               rd_clk,
  input  wire                               rd_rst_n,
  input  wire                               rd_en,
  input  wire  [fifo_bank_pkg::ADDR_W-1:0] rd_addr,
  output logic [fifo_bank_pkg::DATA_W-1:0] rd_data
);

  import fifo_bank_pkg::*;

  logic [DATA_W-1:0] mem [DEPTH];

  // Storage array, written in the producer domain
  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read register holds its value between pops
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

//--- gray_ptr_sync.sv
`timescale 1ns/1ps
`default_nettype none

module gray_ptr_sync (
  input  wire                 dst_clk,
  input  wire                 dst_rst_n,
  input  wire                 fifo_bank_pkg::ptr_t gray_in,
  output fifo_bank_pkg::ptr_t bin_out
);

  import fifo_bank_pkg::*;

  ptr_t gray_meta;
  ptr_t gray_sync;

  // Two flops in the destination domain
  always_ff @(posedge dst_clk or negedge dst_rst_n) begin
    if (!dst_rst_n) begin
      gray_meta <= '0;
      gray_sync <= '0;
    end else begin
      gray_meta <= gray_in;
      gray_sync <= gray_meta;
    end
  end

  // Each binary bit is the XOR of all Gray bits at and above it
  always_comb begin
    bin_out[ADDR_W] = gray_sync[ADDR_W];
    for (int i = ADDR_W - 1; i >= 0; i--) begin
      bin_out[i] = bin_out[i+1] ^ gray_sync[i];
    end
  end

endmodule

`default_nettype wire

//--- async_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module async_fifo (
  input  wire                               wr_clk,
  input  wire                               wr_rst_n,
  input  wire                               wr_en,
  input  wire  [fifo_bank_pkg::DATA_W-1:0] wr_data,
  input  wire                               rd_clk,
  input  wire                               rd_rst_n,
  input  wire                               rd_en,
  output logic [fifo_bank_pkg::DATA_W-1:0] rd_data,
  output logic                              full,
  output logic                              afull,
  output logic                              empty,
  output logic                              aempty
);

  import fifo_bank_pkg::*;

  ptr_t wr_bin;
  ptr_t wr_bin_nxt;
  ptr_t wr_gray;
  ptr_t wr_gray_nxt;

  ptr_t rd_bin;
  ptr_t rd_bin_nxt;
  ptr_t rd_gray;
  ptr_t rd_gray_nxt;

  ptr_t rd_bin_wsync;    // Read pointer seen from wr_clk
  ptr_t rd_gray_wsync;
  ptr_t wr_bin_rsync;    // Write pointer seen from rd_clk
  ptr_t wr_gray_rsync;

  ptr_t wr_used;
  ptr_t rd_used;

  dualport_ram_async i_dualport_ram_async (
    .wr_clk   (wr_clk),
    .wr_en    (wr_en),
    .wr_addr  (wr_bin[ADDR_W-1:0]),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_addr  (rd_bin[ADDR_W-1:0]),
    .rd_data  (rd_data)
  );

  gray_ptr_sync i_rd_ptr_sync (
    .dst_clk   (wr_clk),
    .dst_rst_n (wr_rst_n),
    .gray_in   (rd_gray),
    .bin_out   (rd_bin_wsync)
  );

  gray_ptr_sync i_wr_ptr_sync (
    .dst_clk   (rd_clk),
    .dst_rst_n (rd_rst_n),
    .gray_in   (wr_gray),
    .bin_out   (wr_bin_rsync)
  );

  // ****************************************
  // Write domain
  // ****************************************

  // Enables arrive already qualified by the dispatcher
  assign wr_bin_nxt    = wr_bin + ptr_t'(wr_en);
  assign wr_gray_nxt   = (wr_bin_nxt >> 1) ^ wr_bin_nxt;
  assign rd_gray_wsync = (rd_bin_wsync >> 1) ^ rd_bin_wsync;
  assign wr_used       = wr_bin_nxt - rd_bin_wsync;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin  <= '0;
      wr_gray <= '0;
      full    <= 1'b0;
      afull   <= 1'b0;
    end else begin
      wr_bin  <= wr_bin_nxt;
      wr_gray <= wr_gray_nxt;
      // Full when the writer is one lap ahead of the reader
      full    <= (wr_gray_nxt == {~rd_gray_wsync[ADDR_W:ADDR_W-1],
                                  rd_gray_wsync[ADDR_W-2:0]});
      afull   <= (wr_used >= ptr_t'(AFULL_LEVEL));
    end
  end

  // ****************************************
  // Read domain
  // ****************************************

  assign rd_bin_nxt    = rd_bin + ptr_t'(rd_en);  // Drain only pops non-empty lanes
  assign rd_gray_nxt   = (rd_bin_nxt >> 1) ^ rd_bin_nxt;
  assign wr_gray_rsync = (wr_bin_rsync >> 1) ^ wr_bin_rsync;
  assign rd_used       = wr_bin_rsync - rd_bin_nxt;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin  <= '0;
      rd_gray <= '0;
      empty   <= 1'b1;
      aempty  <= 1'b1;
    end else begin
      rd_bin  <= rd_bin_nxt;
      rd_gray <= rd_gray_nxt;
      empty   <= (rd_gray_nxt == wr_gray_rsync);
      aempty  <= (rd_used <= ptr_t'(AEMPTY_LEVEL));
    end
  end

endmodule

`default_nettype wire

//--- lane_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module lane_dispatch (
  input  wire                                wr_en,
  input  wire  fifo_bank_pkg::bank_word_t   wr_word,
  input  wire  [fifo_bank_pkg::LANES-1:0]   lane_full,
  output logic [fifo_bank_pkg::LANES-1:0]   lane_wr_en,
  output logic [fifo_bank_pkg::DATA_W-1:0]  lane_wr_data,
  output logic                              wr_drop
);

  logic target_full;

  // Full flag of the lane the word is addressed to
  assign target_full = lane_full[wr_word.lane];

  // ****************************************
  // Steering
  // ****************************************

  // All lanes see the same payload, only one gets the enable
  assign lane_wr_data = wr_word.data;

  always_comb begin
    lane_wr_en = '0;
    if (wr_en && !target_full) begin
      lane_wr_en[wr_word.lane] = 1'b1;
    end
  end

  // ****************************************
  // Drop detection
  // ****************************************

  // A strobe aimed at a full lane is lost and flagged in the same cycle
  assign wr_drop = wr_en && target_full;

endmodule

`default_nettype wire

//--- lane_drain.sv
`timescale 1ns/1ps
`default_nettype none

module lane_drain (
  input  wire                                                    rd_clk,
  input  wire                                                    rd_rst_n,
  input  wire                                                    rd_ready,
  input  wire  [fifo_bank_pkg::LANES-1:0]                       lane_empty,
  input  wire  [fifo_bank_pkg::LANES-1:0][fifo_bank_pkg::DATA_W-1:0] lane_rd_data,
  output logic [fifo_bank_pkg::LANES-1:0]                       lane_rd_en,
  output logic                                                   rd_valid,
  output fifo_bank_pkg::bank_word_t                              rd_word
);

  import fifo_bank_pkg::*;

  lane_t rr_ptr;          // Lane with the highest priority this cycle
  lane_t pick_lane;
  logic  pick_found;
  logic  pop;
  lane_t issued_lane;

  // ****************************************
  // Round-robin search
  // ****************************************

  always_comb begin
    lane_t cand;
    pick_found = 1'b0;
    pick_lane  = rr_ptr;
    for (int i = 0; i < LANES; i++) begin
      cand = rr_ptr + LANE_W'(i);  // Wraps around the lane count
      if (!pick_found && !lane_empty[cand]) begin
        pick_found = 1'b1;
        pick_lane  = cand;
      end
    end
  end

  assign pop        = rd_ready && pick_found;
  assign lane_rd_en = pop ? (LANES'(1) << pick_lane) : '0;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rr_ptr      <= '0;
      rd_valid    <= 1'b0;
      issued_lane <= '0;
    end else begin
      rd_valid <= pop;  // Lines up with the RAM read register
      if (pop) begin
        rr_ptr      <= pick_lane + 1'b1;
        issued_lane <= pick_lane;
      end
    end
  end

  // The issued lane's RAM register already holds the popped word
  assign rd_word = {issued_lane, lane_rd_data[issued_lane]};

endmodule

`default_nettype wire

//--- fifo_bank_top.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_bank_top (
  input  wire                               wr_clk,
  input  wire                               wr_rst_n,
  input  wire                               wr_en,
  input  wire  fifo_bank_pkg::bank_word_t  wr_word,
  input  wire                               rd_clk,
  input  wire                               rd_rst_n,
  input  wire                               rd_ready,
  output logic                              wr_drop,
  output logic                              rd_valid,
  output fifo_bank_pkg::bank_word_t         rd_word,
  output logic [fifo_bank_pkg::LANES-1:0]  lane_full,
  output logic [fifo_bank_pkg::LANES-1:0]  lane_afull,
  output logic [fifo_bank_pkg::LANES-1:0]  lane_empty,
  output logic [fifo_bank_pkg::LANES-1:0]  lane_aempty
);

  import fifo_bank_pkg::*;

  logic [LANES-1:0]             lane_wr_en;
  logic [DATA_W-1:0]            lane_wr_data;  // Shared by every lane
  logic [LANES-1:0]             lane_rd_en;
  logic [LANES-1:0][DATA_W-1:0] lane_rd_data;

  lane_dispatch i_lane_dispatch (
    .wr_en        (wr_en),
    .wr_word      (wr_word),
    .lane_full    (lane_full),
    .lane_wr_en   (lane_wr_en),
    .lane_wr_data (lane_wr_data),
    .wr_drop      (wr_drop)
  );

  // One clock-crossing FIFO per lane
  for (genvar g = 0; g < LANES; g++) begin : g_lane
    async_fifo i_async_fifo (
      .wr_clk   (wr_clk),
      .wr_rst_n (wr_rst_n),
      .wr_en    (lane_wr_en[g]),
      .wr_data  (lane_wr_data),
      .rd_clk   (rd_clk),
      .rd_rst_n (rd_rst_n),
      .rd_en    (lane_rd_en[g]),
      .rd_data  (lane_rd_data[g]),
      .full     (lane_full[g]),
      .afull    (lane_afull[g]),
      .empty    (lane_empty[g]),
      .aempty   (lane_aempty[g])
    );
  end

  lane_drain i_lane_drain (
    .rd_clk       (rd_clk),
    .rd_rst_n     (rd_rst_n),
    .rd_ready     (rd_ready),
    .lane_empty   (lane_empty),
    .lane_rd_data (lane_rd_data),
    .lane_rd_en   (lane_rd_en),
    .rd_valid     (rd_valid),
    .rd_word      (rd_word)
  );

endmodule

`default_nettype wire

//--- fifo_bank_props.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_bank_props (
  input wire wr_clk,
  input wire wr_rst_n,
  input wire wr_en,
  input wire rd_clk,
  input wire rd_rst_n,
  input wire rd_en,
  input wire full,
  input wire afull,
  input wire empty,
  input wire aempty
);

  // ****************************************
  // Write domain flags
  // ****************************************

  full_rises_on_push: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    $rose(full) |-> $past(wr_en))
    else $error("full rose without a write");

  afull_covers_full: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    full |-> afull)
    else $error("full is set while afull is clear");

  // ****************************************
  // Read domain flags
  // ****************************************

  // Only a pop can bring the reader level with the writer
  empty_rises_on_pop: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    $rose(empty) |-> $past(rd_en))
    else $error("empty rose without a read");

  aempty_covers_empty: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    empty |-> aempty)
    else $error("empty is set while aempty is clear");

endmodule

bind async_fifo fifo_bank_props i_fifo_bank_props (
  .wr_clk   (wr_clk),
  .wr_rst_n (wr_rst_n),
  .wr_en    (wr_en),
  .rd_clk   (rd_clk),
  .rd_rst_n (rd_rst_n),
  .rd_en    (rd_en),
  .full     (full),
  .afull    (afull),
  .empty    (empty),
  .aempty   (aempty)
);

`default_nettype wire

//--- fifo_bank_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_bank_tb;

  import fifo_bank_pkg::*;

  localparam int NROWS         = 13;
  localparam int LOAD_TIMEOUT  = 40;    // rd_clk cycles
  localparam int DRAIN_TIMEOUT = 3000;

  typedef struct packed {
    lane_t      lane;
    logic [7:0] count;
    logic       ready;     // rd_ready level while the words go in
    logic [7:0] accept;    // Words taken before the lane is full
    logic [1:0] drain;     // 0 none, 1 rd_ready held high, 2 rd_ready toggled at random
    logic       rr_check;
  } row_t;

  // Lane, count, ready, accept, drain, round-robin check
  row_t rows [NROWS] = '{
    '{2'd0, 8'd5,  1'b1, 8'd5,  2'd0, 1'b0},
    '{2'd1, 8'd7,  1'b1, 8'd7,  2'd0, 1'b0},
    '{2'd2, 8'd4,  1'b1, 8'd4,  2'd0, 1'b0},
    '{2'd3, 8'd6,  1'b1, 8'd6,  2'd0, 1'b0},
    '{2'd2, 8'd8,  1'b1, 8'd8,  2'd1, 1'b0},
    '{2'd3, 8'd17, 1'b0, 8'd16, 2'd1, 1'b0},  // Fill to full, one word dropped
    // The fill above ends on lane 3, so the next round starts at lane 0
    '{2'd0, 8'd3,  1'b0, 8'd3,  2'd0, 1'b0},
    '{2'd1, 8'd3,  1'b0, 8'd3,  2'd0, 1'b0},
    '{2'd2, 8'd3,  1'b0, 8'd3,  2'd0, 1'b0},
    '{2'd3, 8'd3,  1'b0, 8'd3,  2'd1, 1'b1},
    '{2'd0, 8'd10, 1'b0, 8'd10, 2'd0, 1'b0},
    '{2'd3, 8'd12, 1'b0, 8'd12, 2'd0, 1'b0},
    '{2'd2, 8'd16, 1'b0, 8'd16, 2'd2, 1'b0}
  };

  logic             wr_clk;
  logic             wr_rst_n;
  logic             wr_en;
  bank_word_t       wr_word;
  logic             rd_clk;
  logic             rd_rst_n;
  logic             rd_ready;
  logic             wr_drop;
  logic             rd_valid;
  bank_word_t       rd_word;
  logic [LANES-1:0] lane_full;
  logic [LANES-1:0] lane_afull;
  logic [LANES-1:0] lane_empty;
  logic [LANES-1:0] lane_aempty;

  integer            seed = 32'haf7d966d;
  logic [DATA_W-1:0] expect_q [LANES][$];  // Accepted words per lane, oldest first
  lane_t             out_log [$];

  fifo_bank_top i_fifo_bank_top (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .wr_en       (wr_en),
    .wr_word     (wr_word),
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .rd_ready    (rd_ready),
    .wr_drop     (wr_drop),
    .rd_valid    (rd_valid),
    .rd_word     (rd_word),
    .lane_full   (lane_full),
    .lane_afull  (lane_afull),
    .lane_empty  (lane_empty),
    .lane_aempty (lane_aempty)
  );

  initial begin
    wr_clk = 1'b0;
    forever #20 wr_clk = ~wr_clk;
  end

  initial begin
    rd_clk = 1'b0;
    forever #14 rd_clk = ~rd_clk;
  end

  // ****************************************
  // Reporting
  // ****************************************

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic compare(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("MISMATCH at %0t: %s is %0h, expected %0h",
                          $time, name, actual, expected));
    end
  endtask

  function automatic bit all_drained();
    bit done;
    done = 1'b1;
    for (int l = 0; l < LANES; l++) begin
      if (expect_q[l].size() != 0) done = 1'b0;
    end
    return done;
  endfunction

  // Every output is matched against the head of its own lane's queue
  always @(negedge rd_clk) begin : monitor
    lane_t lane;
    if (rd_rst_n && rd_valid) begin
      lane = rd_word.lane;
      if (expect_q[lane].size() == 0) begin
        abort_run($sformatf("A word came out of lane %0d with none expected", lane));
      end else begin
        compare("rd_word.data", 32'(rd_word.data), 32'(expect_q[lane].pop_front()));
        out_log.push_back(lane);
      end
    end
  end

  // ****************************************
  // Stimulus
  // ****************************************

  task automatic check_afull_after_settle(input lane_t lane, input logic expected);
    @(posedge wr_clk);
    #2;
    wr_en = 1'b0;
    repeat (3) @(negedge wr_clk);
    compare("lane_afull", 32'(lane_afull[lane]), 32'(expected));
  endtask

  task automatic write_row(input row_t row);
    logic exp_drop;
    for (int i = 0; i < int'(row.count); i++) begin
      if (!row.ready && (i == AFULL_LEVEL - 1 || i == AFULL_LEVEL)) begin
        check_afull_after_settle(row.lane, i >= AFULL_LEVEL);  // i words are in
      end
      exp_drop = (i >= int'(row.accept));
      @(posedge wr_clk);
      #2;
      wr_en        = 1'b1;
      wr_word.lane = row.lane;
      wr_word.data = DATA_W'($random(seed));
      @(negedge wr_clk);
      compare("wr_drop", 32'(wr_drop), 32'(exp_drop));
      if (!exp_drop) expect_q[row.lane].push_back(wr_word.data);
    end
    @(posedge wr_clk);
    #2;
    wr_en = 1'b0;
    @(negedge wr_clk);
    if (row.accept < row.count) compare("lane_full", 32'(lane_full[row.lane]), 32'd1);
  endtask

  task automatic wait_lanes_loaded();
    int cycles;
    cycles = 0;
    while (lane_aempty != '0) begin
      @(negedge rd_clk);
      cycles++;
      if (cycles > LOAD_TIMEOUT) abort_run("The lanes never showed their stored words");
    end
  endtask

  task automatic drain_lanes(input logic [1:0] mode, input logic rr_check);
    int          cycles;
    logic [31:0] rnd;
    cycles = 0;
    out_log.delete();
    while (!all_drained()) begin
      @(posedge rd_clk);
      #2;
      rnd      = $random(seed);
      rd_ready = (mode == 2'd2) ? rnd[0] : 1'b1;
      cycles++;
      if (cycles > DRAIN_TIMEOUT) abort_run("The lanes did not drain in time");
    end
    @(posedge rd_clk);
    #2;
    rd_ready = 1'b0;
    @(negedge rd_clk);
    compare("lane_empty", 32'(lane_empty), 32'({LANES{1'b1}}));
    compare("lane_aempty", 32'(lane_aempty), 32'({LANES{1'b1}}));
    if (rr_check) begin
      for (int k = 0; k < out_log.size(); k++) begin
        compare("rd_word.lane", 32'(out_log[k]), 32'(k % LANES));
      end
    end
  endtask

  initial begin : stimulus
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    wr_en    = 1'b0;
    wr_word  = '0;
    rd_ready = 1'b0;
    repeat (16) @(posedge wr_clk);
    #2;
    wr_rst_n = 1'b1;
    @(posedge rd_clk);
    #2;
    rd_rst_n = 1'b1;

    @(negedge wr_clk);
    compare("lane_full", 32'(lane_full), 32'd0);
    compare("lane_afull", 32'(lane_afull), 32'd0);
    compare("wr_drop", 32'(wr_drop), 32'd0);
    @(negedge rd_clk);
    compare("lane_empty", 32'(lane_empty), 32'({LANES{1'b1}}));
    compare("lane_aempty", 32'(lane_aempty), 32'({LANES{1'b1}}));
    compare("rd_valid", 32'(rd_valid), 32'd0);

    for (int r = 0; r < NROWS; r++) begin
      @(posedge rd_clk);
      #2;
      rd_ready = rows[r].ready;
      write_row(rows[r]);
      if (rows[r].rr_check) wait_lanes_loaded();
      if (rows[r].drain != 2'd0) drain_lanes(rows[r].drain, rows[r].rr_check);
    end

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- fifo_bank.f
fifo_bank_pkg.sv
dualport_ram_async.sv
gray_ptr_sync.sv
async_fifo.sv
lane_dispatch.sv
lane_drain.sv
fifo_bank_top.sv
fifo_bank_props.sv
fifo_bank_tb.sv

//--- Makefile
# Verilator build and run of the FIFO bank testbench

VERILATOR ?= verilator
TOP       ?= fifo_bank_tb
FILELIST  ?= fifo_bank.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?=

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)
